// ==== hw/mips_pkg.sv ====
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int JADDR_W    = 26;
    localparam int PC_J_W     = 28;   // jump field plus two zero bits

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,   // R-type, see funct
        OP_J       = 6'b000010,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function codes under OP_SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL     = 6'b000000,
        FN_SRL     = 6'b000010,
        FN_SRA     = 6'b000011,
        FN_SLLV    = 6'b000100,
        FN_SRLV    = 6'b000110,
        FN_SYSCALL = 6'b001100,
        FN_ADD     = 6'b100000,
        FN_ADDU    = 6'b100001,
        FN_SUB     = 6'b100010,
        FN_SUBU    = 6'b100011,
        FN_AND     = 6'b100100,
        FN_OR      = 6'b100101,
        FN_XOR     = 6'b100110,
        FN_NOR     = 6'b100111,
        FN_SLT     = 6'b101010
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_EQ
    } alu_op_e;

    typedef enum logic [1:0] {
        FLOW_NONE, FLOW_BEQ, FLOW_BNE, FLOW_J
    } flow_e;

endpackage

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import mips_pkg::*;
(
    input  logic [XLEN-1:0]       instr,
    input  logic [XLEN-1:0]       rs_data,
    input  logic [XLEN-1:0]       rt_data,
    output logic [REG_ADDR_W-1:0] rs_num,
    output logic [REG_ADDR_W-1:0] rt_num,
    output logic [XLEN-1:0]       alu_a,
    output logic [XLEN-1:0]       alu_b,
    output alu_op_e               alu_op,
    output logic                  wb_we,
    output logic [REG_ADDR_W-1:0] wb_num,
    output flow_e                 flow,
    output logic                  halt_req
);

    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rd_num;
    logic [REG_ADDR_W-1:0] shamt;
    logic [IMM_W-1:0]      imm;
    logic [XLEN-1:0]       imm_sext;
    logic [XLEN-1:0]       imm_zext;
    logic [XLEN-1:0]       shamt_ext;
    logic [XLEN-1:0]       rs_shamt;   // low bits of rs for the variable shifts

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rs_num = instr[25:21];
    assign rt_num = instr[20:16];
    assign rd_num = instr[15:11];
    assign shamt  = instr[10:6];
    assign imm    = instr[IMM_W-1:0];

    assign imm_sext  = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    assign imm_zext  = {{(XLEN-IMM_W){1'b0}}, imm};
    assign shamt_ext = {{(XLEN-REG_ADDR_W){1'b0}}, shamt};
    assign rs_shamt  = {{(XLEN-REG_ADDR_W){1'b0}}, rs_data[REG_ADDR_W-1:0]};

    always_comb begin
        // defaults: R-type operands, no side effects
        alu_a    = rs_data;
        alu_b    = rt_data;
        alu_op   = ALU_ADD;
        wb_we    = 1'b0;
        wb_num   = rd_num;
        flow     = FLOW_NONE;
        halt_req = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                wb_we = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;   // no overflow trap
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLT:          alu_op = ALU_SLT;   // full signed compare
                    FN_SLL, FN_SRL, FN_SRA: begin
                        alu_a = rt_data;
                        alu_b = shamt_ext;
                        alu_op = (funct == FN_SLL) ? ALU_SLL :
                                 (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_SLLV, FN_SRLV: begin
                        alu_a  = rt_data;
                        alu_b  = rs_shamt;
                        alu_op = (funct == FN_SLLV) ? ALU_SLL : ALU_SRL;
                    end
                    default: begin     // syscall and unknown functions
                        wb_we    = 1'b0;
                        halt_req = 1'b1;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU: begin
                alu_b  = imm_sext;
                wb_we  = 1'b1;
                wb_num = rt_num;
            end
            OP_ANDI: begin
                alu_b  = imm_zext;
                alu_op = ALU_AND;
                wb_we  = 1'b1;
                wb_num = rt_num;
            end
            OP_ORI: begin
                alu_b  = imm_zext;
                alu_op = ALU_OR;
                wb_we  = 1'b1;
                wb_num = rt_num;
            end
            OP_XORI: begin
                alu_b  = imm_zext;
                alu_op = ALU_XOR;
                wb_we  = 1'b1;
                wb_num = rt_num;
            end
            OP_LUI: begin
                // goes through the adder so wb_data stays alu_result
                alu_a  = {imm, {(XLEN-IMM_W){1'b0}}};
                alu_b  = '0;
                wb_we  = 1'b1;
                wb_num = rt_num;
            end
            OP_BEQ, OP_BNE: begin
                alu_op = ALU_EQ;
                flow   = (opcode == OP_BEQ) ? FLOW_BEQ : FLOW_BNE;
            end
            OP_J: begin
                flow = FLOW_J;
            end
            default: begin
                halt_req = 1'b1;   // unknown opcode
            end
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic [REG_ADDR_W-1:0] rs_num,
    input  logic [REG_ADDR_W-1:0] rt_num,
    output logic [XLEN-1:0]       rs_data,
    output logic [XLEN-1:0]       rt_data,
    input  logic                  wb_we,
    input  logic [REG_ADDR_W-1:0] wb_num,
    input  logic [XLEN-1:0]       wb_data,
    input  logic                  halted
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_en;

    // halted blocks every write, r0 never written
    assign wr_en = wb_we && !halted && (wb_num != '0);

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_num] <= wb_data;
        end
    end

    // async reads, r0 hardwired to zero
    assign rs_data = (rs_num == '0) ? '0 : regs[rs_num];
    assign rt_data = (rt_num == '0) ? '0 : regs[rt_num];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu
    import mips_pkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_e         op,
    output logic [XLEN-1:0] result
);

    logic [REG_ADDR_W-1:0] shamt;
    logic                  less;
    logic                  equal;

    assign shamt = b[REG_ADDR_W-1:0];   // only five bits of shift
    assign less  = $signed(a) < $signed(b);
    assign equal = (a == b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;   // wraps
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_NOR: begin
                result = ~(a | b);
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $signed(a) >>> shamt;   // sign fill
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, less};
            end
            ALU_EQ: begin
                // bit 0 feeds the branch condition
                result = {{(XLEN-1){1'b0}}, equal};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== hw/pc_redirect.sv ====
`timescale 1ns/1ps

module pc_redirect
    import mips_pkg::*;
(
    input  logic               clk,
    input  logic               rst_b,
    input  flow_e              flow,
    input  logic [IMM_W-1:0]   imm,
    input  logic [JADDR_W-1:0] jaddr,
    input  logic               cond,       // rs == rt from the ALU
    input  logic               halt_req,
    output logic [XLEN-1:0]    pc_branch,
    output logic               pc_branch_en,
    output logic [PC_J_W-1:0]  pc_j,
    output logic               pc_j_en,
    output logic               halted
);

    logic [XLEN-1:0] branch_target;
    logic            branch_take;
    logic            jump_take;

    // displacement only, no pc added here
    assign branch_target = {{(XLEN-IMM_W-2){imm[IMM_W-1]}}, imm, 2'b00} + XLEN'(4);

    assign branch_take = !halted && (((flow == FLOW_BEQ) && cond) ||
                                     ((flow == FLOW_BNE) && !cond));
    assign jump_take   = !halted && (flow == FLOW_J);

    always_ff @(posedge clk) begin
        if (!rst_b) begin
            pc_branch    <= '0;
            pc_branch_en <= 1'b0;
            pc_j         <= '0;
            pc_j_en      <= 1'b0;
            halted       <= 1'b0;
        end else begin
            pc_branch_en <= branch_take;
            pc_j_en      <= jump_take;
            if (branch_take) pc_branch <= branch_target;   // hold otherwise
            if (jump_take) pc_j <= {jaddr, 2'b00};
            if (halt_req) halted <= 1'b1;   // sticky until reset
        end
    end

endmodule

// ==== hw/mips_exec_core.sv ====
`timescale 1ns/1ps

module mips_exec_core
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic [XLEN-1:0]       instr,
    output logic                  wb_we,
    output logic [REG_ADDR_W-1:0] wb_num,
    output logic [XLEN-1:0]       wb_data,
    output logic [XLEN-1:0]       pc_branch,
    output logic                  pc_branch_en,
    output logic [PC_J_W-1:0]     pc_j,
    output logic                  pc_j_en,
    output logic                  halted
);

    logic [REG_ADDR_W-1:0] rs_num;
    logic [REG_ADDR_W-1:0] rt_num;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic [XLEN-1:0]       alu_a;
    logic [XLEN-1:0]       alu_b;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       alu_result;
    flow_e                 flow;
    logic                  halt_req;

    assign wb_data = alu_result;   // every writeback comes from the ALU

    instr_decoder i_decoder (
        .instr    (instr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .rs_num   (rs_num),
        .rt_num   (rt_num),
        .alu_a    (alu_a),
        .alu_b    (alu_b),
        .alu_op   (alu_op),
        .wb_we    (wb_we),
        .wb_num   (wb_num),
        .flow     (flow),
        .halt_req (halt_req)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_we   (wb_we),
        .wb_num  (wb_num),
        .wb_data (alu_result),
        .halted  (halted)
    );

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    pc_redirect i_pc_redirect (
        .clk          (clk),
        .rst_b        (rst_b),
        .flow         (flow),
        .imm          (instr[IMM_W-1:0]),
        .jaddr        (instr[JADDR_W-1:0]),
        .cond         (alu_result[0]),   // EQ result
        .halt_req     (halt_req),
        .pc_branch    (pc_branch),
        .pc_branch_en (pc_branch_en),
        .pc_j         (pc_j),
        .pc_j_en      (pc_j_en),
        .halted       (halted)
    );

endmodule

// ==== verification/mips_ref_model.svh ====
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// shadow of the architectural state, advanced once per checked cycle
logic [XLEN-1:0]   shadow_regs [2**REG_ADDR_W];
logic              exp_halted;
logic              exp_branch_en;
logic [XLEN-1:0]   exp_branch;
logic              exp_j_en;
logic [PC_J_W-1:0] exp_j;

function automatic void reset_model();
    for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        shadow_regs[i] = '0;
    end
    exp_halted    = 1'b0;
    exp_branch_en = 1'b0;
    exp_branch    = '0;
    exp_j_en      = 1'b0;
    exp_j         = '0;
endfunction

// expected writeback and redirect request of one instruction
function automatic void predict(
    input  logic [XLEN-1:0]       ins,
    output logic                  we,
    output logic [REG_ADDR_W-1:0] num,
    output logic [XLEN-1:0]       data,
    output logic                  br_cond,
    output logic [XLEN-1:0]       br_target,
    output logic                  j_req,
    output logic [PC_J_W-1:0]     j_target,
    output logic                  halt
);
    logic [XLEN-1:0]       rs_v;
    logic [XLEN-1:0]       rt_v;
    logic [XLEN-1:0]       simm;
    logic [XLEN-1:0]       zimm;
    logic [REG_ADDR_W-1:0] sa;
    rs_v      = shadow_regs[ins[25:21]];   // entry 0 is never written
    rt_v      = shadow_regs[ins[20:16]];
    simm      = {{16{ins[15]}}, ins[15:0]};
    zimm      = {16'h0000, ins[15:0]};
    sa        = ins[10:6];
    we        = 1'b0;
    num       = ins[20:16];
    data      = '0;
    br_cond   = 1'b0;
    br_target = (simm << 2) + 32'd4;      // displacement past the delay slot
    j_req     = 1'b0;
    j_target  = {ins[25:0], 2'b00};
    halt      = 1'b0;
    case (ins[31:26])
        OP_SPECIAL: begin
            we  = 1'b1;
            num = ins[15:11];
            case (ins[5:0])
                FN_ADD, FN_ADDU: data = rs_v + rt_v;
                FN_SUB, FN_SUBU: data = rs_v - rt_v;
                FN_AND:  data = rs_v & rt_v;
                FN_OR:   data = rs_v | rt_v;
                FN_XOR:  data = rs_v ^ rt_v;
                FN_NOR:  data = ~(rs_v | rt_v);
                FN_SLL:  data = rt_v << sa;
                FN_SRL:  data = rt_v >> sa;
                FN_SRA:  data = $signed(rt_v) >>> sa;
                FN_SLLV: data = rt_v << rs_v[4:0];
                FN_SRLV: data = rt_v >> rs_v[4:0];
                FN_SLT:  data = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
                default: begin
                    we   = 1'b0;   // syscall or unknown function
                    halt = 1'b1;
                end
            endcase
        end
        OP_ADDI, OP_ADDIU: begin
            we   = 1'b1;
            data = rs_v + simm;
        end
        OP_ANDI: begin
            we   = 1'b1;
            data = rs_v & zimm;
        end
        OP_ORI: begin
            we   = 1'b1;
            data = rs_v | zimm;
        end
        OP_XORI: begin
            we   = 1'b1;
            data = rs_v ^ zimm;
        end
        OP_LUI: begin
            we   = 1'b1;
            data = {ins[15:0], 16'h0000};
        end
        OP_BEQ:  br_cond = (rs_v == rt_v);
        OP_BNE:  br_cond = (rs_v != rt_v);
        OP_J:    j_req = 1'b1;
        default: halt = 1'b1;
    endcase
endfunction

// state after the clock edge that ends the instruction's cycle
function automatic void commit_model(
    input logic                  we,
    input logic [REG_ADDR_W-1:0] num,
    input logic [XLEN-1:0]       data,
    input logic                  br_cond,
    input logic [XLEN-1:0]       br_target,
    input logic                  j_req,
    input logic [PC_J_W-1:0]     j_target,
    input logic                  halt
);
    if (we && !exp_halted && num != 5'd0) begin
        shadow_regs[num] = data;
    end
    exp_branch_en = br_cond && !exp_halted;
    exp_j_en      = j_req && !exp_halted;
    if (exp_branch_en) begin
        exp_branch = br_target;
    end
    if (exp_j_en) begin
        exp_j = j_target;
    end
    if (halt) begin
        exp_halted = 1'b1;   // sticky
    end
endfunction

`endif

// ==== verification/tb_mips_exec_core.sv ====
`timescale 1ns/1ps

module tb_mips_exec_core
    import mips_pkg::*;
();

    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 8;
    localparam int HALT_TIMEOUT  = 4;
    localparam int RANDOM_COUNT  = 300;

    // kept ALU encodings for the random mix
    localparam logic [14*6-1:0] ALU_FUNCTS = {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
        FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SLT};
    localparam logic [6*6-1:0]  IMM_OPS = {OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    logic                  clk = 1'b0;
    logic                  rst_b;
    logic [XLEN-1:0]       instr;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_num;
    logic [XLEN-1:0]       wb_data;
    logic [XLEN-1:0]       pc_branch;
    logic                  pc_branch_en;
    logic [PC_J_W-1:0]     pc_j;
    logic                  pc_j_en;
    logic                  halted;

    int check_errors   = 0;
    int timeout_errors = 0;
    bit timed_out      = 1'b0;

    // predicted values of the instruction in the current cycle
    logic                  p_we;
    logic [REG_ADDR_W-1:0] p_num;
    logic [XLEN-1:0]       p_data;
    logic                  p_br_cond;
    logic [XLEN-1:0]       p_br_target;
    logic                  p_j_req;
    logic [PC_J_W-1:0]     p_j_target;
    logic                  p_halt;

    `include "mips_ref_model.svh"

    always #5 clk = ~clk;

    mips_exec_core i_dut (
        .clk          (clk),
        .rst_b        (rst_b),
        .instr        (instr),
        .wb_we        (wb_we),
        .wb_num       (wb_num),
        .wb_data      (wb_data),
        .pc_branch    (pc_branch),
        .pc_branch_en (pc_branch_en),
        .pc_j         (pc_j),
        .pc_j_en      (pc_j_en),
        .halted       (halted)
    );

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
                     name, got, exp, $time);
            check_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT: %s", what);
        timeout_errors++;
        timed_out = 1'b1;
    endtask

    function automatic logic [XLEN-1:0] r_type(input funct_e fn,
                                               input logic [4:0] rs, rt, rd, sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [XLEN-1:0] i_type(input opcode_e op, input logic [4:0] rs, rt,
                                               input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [XLEN-1:0] j_type(input logic [25:0] addr);
        return {OP_J, addr};
    endfunction

    function automatic logic [XLEN-1:0] random_alu_instr();
        logic [XLEN-1:0]   r;
        logic [XLEN-1:0]   pick;
        logic [14*6-1:0]   sel;
        logic [6*6-1:0]    op_sel;
        r    = $urandom;
        pick = $urandom % 20;
        if (pick < 14) begin
            sel = ALU_FUNCTS >> (6 * pick);
            return r_type(funct_e'(sel[5:0]), r[25:21], r[20:16], r[15:11], r[10:6]);
        end
        op_sel = IMM_OPS >> (6 * (pick - 14));
        return i_type(opcode_e'(op_sel[5:0]), r[25:21], r[20:16], r[15:0]);
    endfunction

    task automatic issue(input logic [XLEN-1:0] ins);
        @(posedge clk);
        instr <= ins;
    endtask

    task automatic apply_reset();
        bit released;
        @(posedge clk);
        rst_b <= 1'b0;
        instr <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_b    <= 1'b1;
        released = 1'b0;
        for (int i = 0; i < RESET_TIMEOUT && !released; i++) begin
            @(negedge clk);
            released = (halted === 1'b0);
        end
        if (!released) report_timeout("halted did not clear after reset was released");
    endtask

    task automatic wait_for_halt();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < HALT_TIMEOUT && !seen; i++) begin
            @(negedge clk);
            seen = (halted === 1'b1);
        end
        if (!seen) report_timeout("halted never rose after the halting instruction");
    endtask

    task automatic run_halt(input logic [XLEN-1:0] halt_ins);
        issue(i_type(OP_ORI, 5'd0, 5'd20, 16'h00aa));
        issue(r_type(FN_ADD, 5'd20, 5'd20, 5'd21, 5'd0));
        issue(halt_ins);
        wait_for_halt();
        if (timed_out) return;
        issue(i_type(OP_ORI, 5'd0, 5'd20, 16'h5555));    // must not land
        issue(r_type(FN_SUB, 5'd20, 5'd21, 5'd22, 5'd0));
        for (int k = 0; k < 6; k++) begin
            issue(random_alu_instr());
        end
        issue(i_type(OP_BEQ, 5'd0, 5'd0, 16'h0008));     // enable stays low
        issue(j_type(26'h0abcdef));
        issue(r_type(FN_OR, 5'd20, 5'd0, 5'd23, 5'd0));  // r20 still 0xaa
        issue(r_type(FN_OR, 5'd21, 5'd22, 5'd24, 5'd0));
    endtask

    task automatic finish_run();
        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // writeback of this cycle plus redirect and halt of the previous one
    always @(negedge clk) begin
        if (!rst_b) begin
            reset_model();
        end else begin
            check_value("halted", XLEN'(halted), XLEN'(exp_halted));
            check_value("pc_branch_en", XLEN'(pc_branch_en), XLEN'(exp_branch_en));
            check_value("pc_branch", pc_branch, exp_branch);
            check_value("pc_j_en", XLEN'(pc_j_en), XLEN'(exp_j_en));
            check_value("pc_j", XLEN'(pc_j), XLEN'(exp_j));
            predict(instr, p_we, p_num, p_data, p_br_cond, p_br_target, p_j_req, p_j_target,
                    p_halt);
            check_value("wb_we", XLEN'(wb_we), XLEN'(p_we));
            if (p_we) begin
                check_value("wb_num", XLEN'(wb_num), XLEN'(p_num));
                check_value("wb_data", wb_data, p_data);
            end
            commit_model(p_we, p_num, p_data, p_br_cond, p_br_target, p_j_req, p_j_target,
                         p_halt);
        end
    end

    initial begin
        logic [XLEN-1:0] r;
        rst_b <= 1'b0;
        instr <= '0;
        void'($urandom(79));
        apply_reset();
        if (!timed_out) begin
            // untouched registers read zero
            issue(r_type(FN_OR, 5'd7, 5'd9, 5'd5, 5'd0));
            issue(r_type(FN_SUB, 5'd31, 5'd17, 5'd6, 5'd0));
            issue(i_type(OP_BEQ, 5'd3, 5'd4, 16'h0010));
            // immediate loads and dropped r0 writes
            issue(i_type(OP_LUI, 5'd0, 5'd1, 16'h1234));
            issue(i_type(OP_ORI, 5'd1, 5'd1, 16'h5678));
            issue(i_type(OP_ADDI, 5'd0, 5'd2, 16'hfffb));
            issue(i_type(OP_ADDIU, 5'd2, 5'd3, 16'h7fff));
            issue(i_type(OP_LUI, 5'd0, 5'd0, 16'hdead));
            issue(i_type(OP_ORI, 5'd1, 5'd0, 16'h00ff));
            issue(r_type(FN_OR, 5'd0, 5'd0, 5'd5, 5'd0));
            issue(r_type(FN_ADD, 5'd1, 5'd0, 5'd6, 5'd0));
            for (int k = 0; k < RANDOM_COUNT; k++) begin
                issue(random_alu_instr());
            end
            // r10 matches r12 but not r11
            issue(i_type(OP_ORI, 5'd0, 5'd10, 16'h0011));
            issue(i_type(OP_ORI, 5'd0, 5'd11, 16'h0022));
            issue(i_type(OP_ORI, 5'd0, 5'd12, 16'h0011));
            for (int k = 0; k < 8; k++) begin
                r = $urandom;
                issue(i_type(OP_BEQ, 5'd10, 5'd12, r[15:0]));
                issue(i_type(OP_BEQ, 5'd10, 5'd11, r[31:16]));
                issue(i_type(OP_BNE, 5'd10, 5'd11, r[31:16]));
                issue(i_type(OP_BNE, 5'd10, 5'd12, r[15:0]));
                issue(j_type(r[25:0]));
            end
            run_halt(r_type(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
        end
        if (!timed_out) begin
            apply_reset();
        end
        if (!timed_out) begin
            run_halt(r_type(funct_e'(6'b011000), 5'd3, 5'd4, 5'd5, 5'd0));   // mult is dropped
        end
        issue('0);
        issue('0);
        @(negedge clk);
        #1;
        finish_run();
    end

endmodule

// ==== mips_exec_core.f ====
hw/mips_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/pc_redirect.sv
hw/mips_exec_core.sv
+incdir+verification
verification/tb_mips_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the execute slice testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_mips_exec_core \
    -f mips_exec_core.f \
    -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result line, see sim.log"
    exit 1
fi
exit 0
